/* design/fma_multiply_align.sv */
`timescale 1ns/1ps

module fma_multiply_align (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     u_valid,
  input  logic                     u_sa,
  input  logic                     u_sb,
  input  logic                     u_sc,
  input  fp_pkg::exp_t             u_ea,
  input  fp_pkg::exp_t             u_eb,
  input  fp_pkg::exp_t             u_ec,
  input  fp_pkg::mant_t            u_ma,
  input  fp_pkg::mant_t            u_mb,
  input  fp_pkg::mant_t            u_mc,
  input  fp_pkg::fp_class_e        u_cla,
  input  fp_pkg::fp_class_e        u_clb,
  input  fp_pkg::fp_class_e        u_clc,
  input  fpu_csr_pkg::round_mode_e u_mode,
  input  logic                     u_den,
  output logic                     m_valid,
  output fp_pkg::sum_t             m_sum,
  output logic                     m_sign,
  output fp_pkg::exp_t             m_exp,
  output logic                     m_sticky,
  output logic                     m_zero,
  output logic                     m_special,
  output fp_pkg::fp64_t            m_special_res,
  output logic                     m_inv,
  output fpu_csr_pkg::round_mode_e m_mode,
  output logic                     m_den
);
  import fp_pkg::*;
  import fpu_csr_pkg::*;

  // both operands put their top bit at SUM_W-3, leaving two bits of headroom
  localparam int PROD_LSB = SUM_W - 2 - PROD_W;
  localparam int C_LSB = SUM_W - 2 - MANT_W;

  prod_t       prod;
  exp_t        ep_top, top_exp, exp_gap;
  shamt_t      shift;
  logic        psign, prod_zero, c_zero, c_big;
  logic        ab_nan, any_nan, any_snan, a_inf, b_inf, c_inf;
  logic        prod_inf, mul_inv, add_inv, special;
  fp64_t       special_res;

  always_comb begin
    prod = prod_t'(u_ma) * prod_t'(u_mb);
    ep_top = u_ea + u_eb - exp_t'(EXP_BIAS) + exp_t'(1);  // weight of product bit 105
    psign = u_sa ^ u_sb;
    prod_zero = (u_cla == CLS_ZERO) || (u_clb == CLS_ZERO);
    c_zero = (u_clc == CLS_ZERO);
    // a zero product never wins the alignment, its exponent is meaningless
    c_big = prod_zero || (!c_zero && (u_ec > ep_top));
    top_exp = c_big ? u_ec : ep_top;
    exp_gap = c_big ? u_ec - ep_top : ep_top - u_ec;
    if (exp_gap < 0) shift = '0;
    else if (exp_gap > 255) shift = '1;
    else shift = exp_gap[7:0];

    ab_nan = (u_cla inside {CLS_QNAN, CLS_SNAN}) || (u_clb inside {CLS_QNAN, CLS_SNAN});
    any_nan = ab_nan || (u_clc inside {CLS_QNAN, CLS_SNAN});
    any_snan = (u_cla == CLS_SNAN) || (u_clb == CLS_SNAN) || (u_clc == CLS_SNAN);
    a_inf = (u_cla == CLS_INF);
    b_inf = (u_clb == CLS_INF);
    c_inf = (u_clc == CLS_INF);
    mul_inv = (a_inf && (u_clb == CLS_ZERO)) || (b_inf && (u_cla == CLS_ZERO));
    prod_inf = (a_inf || b_inf) && !prod_zero && !ab_nan;
    add_inv = prod_inf && c_inf && (psign != u_sc);

    special = 1'b1;
    special_res = QNAN_DEFAULT;
    if (any_nan || mul_inv || add_inv) special_res = QNAN_DEFAULT;
    else if (prod_inf) special_res = {psign, 11'h7ff, 52'b0};
    else if (c_inf) special_res = {u_sc, 11'h7ff, 52'b0};
    else if (prod_zero && c_zero) special_res = {psign & u_sc, 63'b0};  // -0 only if both are -0
    else special = 1'b0;
  end

  logic        s1_valid, s1_c_big, s1_psign, s1_sc, s1_sub;
  logic        s1_special, s1_inv, s1_den;
  prod_t       s1_prod;
  mant_t       s1_mc;
  shamt_t      s1_shift;
  exp_t        s1_top_exp;
  fp64_t       s1_special_res;
  round_mode_e s1_mode;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
      m_valid  <= 1'b0;
    end else begin
      s1_valid <= u_valid;
      m_valid  <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    s1_prod        <= prod;
    s1_mc          <= u_mc;
    s1_c_big       <= c_big;
    s1_shift       <= shift;
    s1_top_exp     <= top_exp + exp_t'(2);  // field bit 162 is two above the operand top
    s1_psign       <= psign;
    s1_sc          <= u_sc;
    s1_sub         <= psign ^ u_sc;
    s1_special     <= special;
    s1_special_res <= special_res;
    s1_inv         <= any_snan || mul_inv || add_inv;
    s1_mode        <= u_mode;
    s1_den         <= u_den;
  end

  sum_t                 prod_f, c_f, big_f, small_f, small_al, mag;
  logic [2*SUM_W-1:0]   shifted;
  logic [SUM_W:0]       raw;
  logic                 lost, neg;

  always_comb begin
    prod_f = {2'b00, s1_prod, {PROD_LSB{1'b0}}};
    c_f = {2'b00, s1_mc, {C_LSB{1'b0}}};
    big_f = s1_c_big ? c_f : prod_f;
    small_f = s1_c_big ? prod_f : c_f;
    shifted = {small_f, {SUM_W{1'b0}}} >> s1_shift;
    small_al = shifted[2*SUM_W-1 -: SUM_W];
    lost = |shifted[SUM_W-1:0];
    // lost bits only exist when the big operand clearly dominates, so borrowing
    // one LSB keeps the truncated difference below the true one
    if (s1_sub) raw = {1'b0, big_f} - {1'b0, small_al} - {{SUM_W{1'b0}}, lost};
    else raw = {1'b0, big_f} + {1'b0, small_al};
    neg = raw[SUM_W];
    mag = neg ? (~raw[SUM_W-1:0] + 1'b1) : raw[SUM_W-1:0];
  end

  always_ff @(posedge clk) begin
    m_sum         <= mag;
    m_sign        <= (s1_c_big ? s1_sc : s1_psign) ^ neg;
    m_exp         <= s1_top_exp;
    m_sticky      <= lost;
    m_zero        <= (mag == '0) && !lost;
    m_special     <= s1_special;
    m_special_res <= s1_special_res;
    m_inv         <= s1_inv;
    m_mode        <= s1_mode;
    m_den         <= s1_den;
  end

endmodule

/* design/fma_normalize_round.sv */
`timescale 1ns/1ps

module fma_normalize_round (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     m_valid,
  input  fp_pkg::sum_t             m_sum,
  input  logic                     m_sign,
  input  fp_pkg::exp_t             m_exp,
  input  logic                     m_sticky,
  input  logic                     m_zero,
  input  logic                     m_special,
  input  fp_pkg::fp64_t            m_special_res,
  input  logic                     m_inv,
  input  fpu_csr_pkg::round_mode_e m_mode,
  input  logic                     m_den,
  output logic                     out_valid,
  output fp_pkg::fp64_t            res,
  output fpu_csr_pkg::flags_t      raise
);
  import fp_pkg::*;
  import fpu_csr_pkg::*;

  localparam int GUARD_POS = SUM_W - 1 - MANT_W;  // first bit below the kept mantissa

  shamt_t              lz;
  sum_t                norm;
  mant_t               mant;
  logic [MANT_W:0]     mant_rnd;
  logic                guard, sticky, round_up, ovf, unf;
  exp_t                exp_n, exp_r;
  frac_t               frac_r;
  fp64_t               res_n;
  flags_t              flags_n;

  always_comb begin
    lz = '0;
    for (int i = 0; i < SUM_W; i++) begin
      if (m_sum[i]) lz = shamt_t'(SUM_W - 1 - i);  // highest set bit wins
    end
    norm = m_sum << lz;
    exp_n = m_exp - exp_t'({5'b0, lz});

    mant = norm[SUM_W-1 -: MANT_W];
    guard = norm[GUARD_POS];
    sticky = (|norm[GUARD_POS-1:0]) || m_sticky;
    round_up = (m_mode == RND_EVEN) && guard && (sticky || mant[0]);
    mant_rnd = {1'b0, mant} + {{MANT_W{1'b0}}, round_up};

    // a carry out of the mantissa means it became 1.000..0 one binade higher
    if (mant_rnd[MANT_W]) begin
      exp_r = exp_n + exp_t'(1);
      frac_r = mant_rnd[FRAC_W:1];
    end else begin
      exp_r = exp_n;
      frac_r = mant_rnd[FRAC_W-1:0];
    end

    ovf = (exp_r > EXP_MAX);
    unf = (exp_r < 1);

    flags_n = '0;
    flags_n[FLG_INV] = m_inv;
    flags_n[FLG_DEN] = m_den;

    if (m_special) begin
      res_n = m_special_res;
    end else if (m_zero) begin
      res_n = '0;  // exact cancellation is +0 in both modes
    end else if (ovf) begin
      res_n = (m_mode == RND_TRUNC) ? {m_sign, 11'h7fe, {FRAC_W{1'b1}}}
                                    : {m_sign, 11'h7ff, {FRAC_W{1'b0}}};
      flags_n[FLG_OVF] = 1'b1;
      flags_n[FLG_INX] = 1'b1;
    end else if (unf) begin
      res_n = {m_sign, 63'b0};  // no gradual underflow, flush to signed zero
      flags_n[FLG_UNF] = 1'b1;
      flags_n[FLG_INX] = 1'b1;
    end else begin
      res_n = {m_sign, exp_r[10:0], frac_r};
      flags_n[FLG_INX] = guard || sticky;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      res       <= '0;
      raise     <= '0;
    end else begin
      out_valid <= m_valid;
      res       <= res_n;
      raise     <= m_valid ? flags_n : '0;  // flags are only meaningful with the strobe
    end
  end

endmodule

/* design/fma_unit.sv */
`timescale 1ns/1ps

module fma_unit (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                in_valid,
  input  fp_pkg::fp64_t       a,
  input  fp_pkg::fp64_t       b,
  input  fp_pkg::fp64_t       c,
  input  fpu_csr_pkg::fpcsr_t fpcsr,
  output logic                out_valid,
  output fp_pkg::fp64_t       res,
  output fpu_csr_pkg::flags_t raise
);
  import fp_pkg::*;
  import fpu_csr_pkg::*;

  // unpack to multiply_align
  logic        u_valid, u_sa, u_sb, u_sc, u_den;
  exp_t        u_ea, u_eb, u_ec;
  mant_t       u_ma, u_mb, u_mc;
  fp_class_e   u_cla, u_clb, u_clc;
  round_mode_e u_mode;

  // multiply_align to normalize_round
  logic        m_valid, m_sign, m_sticky, m_zero, m_special, m_inv, m_den;
  sum_t        m_sum;
  exp_t        m_exp;
  fp64_t       m_special_res;
  round_mode_e m_mode;

  fma_unpack u_unpack0 (
    .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .a(a), .b(b), .c(c), .fpcsr(fpcsr),
    .u_valid(u_valid), .u_sa(u_sa), .u_sb(u_sb), .u_sc(u_sc),
    .u_ea(u_ea), .u_eb(u_eb), .u_ec(u_ec), .u_ma(u_ma), .u_mb(u_mb), .u_mc(u_mc),
    .u_cla(u_cla), .u_clb(u_clb), .u_clc(u_clc), .u_mode(u_mode), .u_den(u_den)
  );

  fma_multiply_align u_mul0 (
    .clk(clk), .rst_n(rst_n),
    .u_valid(u_valid), .u_sa(u_sa), .u_sb(u_sb), .u_sc(u_sc),
    .u_ea(u_ea), .u_eb(u_eb), .u_ec(u_ec), .u_ma(u_ma), .u_mb(u_mb), .u_mc(u_mc),
    .u_cla(u_cla), .u_clb(u_clb), .u_clc(u_clc), .u_mode(u_mode), .u_den(u_den),
    .m_valid(m_valid), .m_sum(m_sum), .m_sign(m_sign), .m_exp(m_exp),
    .m_sticky(m_sticky), .m_zero(m_zero), .m_special(m_special),
    .m_special_res(m_special_res), .m_inv(m_inv), .m_mode(m_mode), .m_den(m_den)
  );

  fma_normalize_round u_rnd0 (
    .clk(clk), .rst_n(rst_n),
    .m_valid(m_valid), .m_sum(m_sum), .m_sign(m_sign), .m_exp(m_exp),
    .m_sticky(m_sticky), .m_zero(m_zero), .m_special(m_special),
    .m_special_res(m_special_res), .m_inv(m_inv), .m_mode(m_mode), .m_den(m_den),
    .out_valid(out_valid), .res(res), .raise(raise)
  );

endmodule

/* design/fma_unpack.sv */
`timescale 1ns/1ps

module fma_unpack (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     in_valid,
  input  fp_pkg::fp64_t            a,
  input  fp_pkg::fp64_t            b,
  input  fp_pkg::fp64_t            c,
  input  fpu_csr_pkg::fpcsr_t      fpcsr,
  output logic                     u_valid,
  output logic                     u_sa,
  output logic                     u_sb,
  output logic                     u_sc,
  output fp_pkg::exp_t             u_ea,
  output fp_pkg::exp_t             u_eb,
  output fp_pkg::exp_t             u_ec,
  output fp_pkg::mant_t            u_ma,
  output fp_pkg::mant_t            u_mb,
  output fp_pkg::mant_t            u_mc,
  output fp_pkg::fp_class_e        u_cla,
  output fp_pkg::fp_class_e        u_clb,
  output fp_pkg::fp_class_e        u_clc,
  output fpu_csr_pkg::round_mode_e u_mode,
  output logic                     u_den
);
  import fp_pkg::*;
  import fpu_csr_pkg::*;

  // a subnormal lands in CLS_ZERO, it is never carried as a number
  function automatic fp_class_e classify(input fp64_t x);
    logic [10:0] e;
    frac_t       f;
    e = x[62:52];
    f = x[FRAC_W-1:0];
    if (e == '0) return CLS_ZERO;
    if (e != '1) return CLS_NORMAL;
    if (f == '0) return CLS_INF;
    return f[FRAC_W-1] ? CLS_QNAN : CLS_SNAN;
  endfunction

  function automatic logic is_subnormal(input fp64_t x);
    return (x[62:52] == '0) && (x[FRAC_W-1:0] != '0);
  endfunction

  // zero class gets exponent 0 and an empty mantissa so the datapath sees a true zero
  function automatic exp_t exp_of(input fp64_t x, input fp_class_e cls);
    return (cls == CLS_ZERO) ? exp_t'(0) : exp_t'({2'b00, x[62:52]});
  endfunction

  function automatic mant_t mant_of(input fp64_t x, input fp_class_e cls);
    return (cls == CLS_ZERO) ? mant_t'(0) : {1'b1, x[FRAC_W-1:0]};
  endfunction

  fp_class_e   cla, clb, clc;
  round_mode_e mode;
  logic        any_sub;

  always_comb begin
    cla = classify(a);
    clb = classify(b);
    clc = classify(c);
    any_sub = is_subnormal(a) || is_subnormal(b) || is_subnormal(c);
    mode = (fpcsr[CSR_RND_HI:CSR_RND_LO] == RND_FIELD_TRUNC) ? RND_TRUNC : RND_EVEN;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      u_valid <= 1'b0;
    end else begin
      u_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    u_sa   <= a[63];
    u_sb   <= b[63];
    u_sc   <= c[63];
    u_ea   <= exp_of(a, cla);
    u_eb   <= exp_of(b, clb);
    u_ec   <= exp_of(c, clc);
    u_ma   <= mant_of(a, cla);
    u_mb   <= mant_of(b, clb);
    u_mc   <= mant_of(c, clc);
    u_cla  <= cla;
    u_clb  <= clb;
    u_clc  <= clc;
    u_mode <= mode;
    u_den  <= any_sub && fpcsr[CSR_DAZ];
  end

endmodule

/* design/fp_pkg.sv */
package fp_pkg;

  // binary64 layout
  localparam int FRAC_W = 52;
  localparam int MANT_W = FRAC_W + 1;  // stored fraction plus the hidden one
  localparam int PROD_W = 2 * MANT_W;

  // the product sits below two headroom bits, and the space under it holds
  // the guard bits for the aligned operand
  localparam int SUM_W = 163;

  localparam int EXP_BIAS = 1023;
  localparam int EXP_MAX = 2046;  // largest biased exponent of a finite number

  typedef logic [63:0] fp64_t;
  typedef logic signed [12:0] exp_t;  // biased, but with room for product and sum exponents
  typedef logic [FRAC_W-1:0] frac_t;
  typedef logic [MANT_W-1:0] mant_t;
  typedef logic [PROD_W-1:0] prod_t;
  typedef logic [SUM_W-1:0] sum_t;
  typedef logic [7:0] shamt_t;

  typedef enum logic [2:0] {
    CLS_ZERO,
    CLS_NORMAL,
    CLS_INF,
    CLS_QNAN,
    CLS_SNAN
  } fp_class_e;

  localparam fp64_t QNAN_DEFAULT = 64'h7ff8_0000_0000_0000;

endpackage

/* design/fpu_csr_pkg.sv */
package fpu_csr_pkg;

  // control word
  typedef logic [3:0] fpcsr_t;

  localparam int CSR_RND_LO = 0;
  localparam int CSR_RND_HI = 1;
  localparam int CSR_DAZ = 2;  // bit 3 is reserved

  // only the two modes this unit implements; the other field codes round to even
  typedef enum logic [1:0] {
    RND_EVEN = 2'd0,
    RND_TRUNC = 2'd1
  } round_mode_e;

  // exception flags raised with each result
  typedef logic [4:0] flags_t;

  localparam int FLG_INV = 0;
  localparam int FLG_OVF = 1;
  localparam int FLG_UNF = 2;
  localparam int FLG_INX = 3;
  localparam int FLG_DEN = 4;

  // the mode field values that select truncation
  localparam logic [1:0] RND_FIELD_TRUNC = 2'd1;

endpackage

/* dv/fma_unit_assertions.sv */
`timescale 1ns/1ps

module fma_unit_assertions (
  input logic                clk,
  input logic                rst_n,
  input logic                in_valid,
  input logic                out_valid,
  input fp_pkg::fp64_t       res,
  input fpu_csr_pkg::flags_t raise
);
  import fp_pkg::*;
  import fpu_csr_pkg::*;

  logic res_nan;

  assign res_nan = (res[62:52] == 11'h7ff) && (res[51:0] != '0);

  // fixed four-cycle latency, nothing stalls or drops
  assert property (@(posedge clk) disable iff (!rst_n) out_valid == $past(in_valid, 4))
    else $error("out_valid is not in_valid delayed by four cycles");

  assert property (@(posedge clk) disable iff (!rst_n) !out_valid |-> raise == '0)
    else $error("raise is nonzero without out_valid");

  assert property (@(posedge clk) disable iff (!rst_n) (out_valid && res_nan) |-> !raise[FLG_OVF])
    else $error("a NaN result carries the overflow flag");

endmodule

/* dv/fma_unit_tb.sv */
`timescale 1ns/1ps

module fma_unit_tb;
  import fp_pkg::*;
  import fpu_csr_pkg::*;

  localparam int N_EXACT = 200;
  localparam int N_PROD = 200;  // each one also runs again in truncation mode
  localparam int N_SPEC = 200;
  localparam int N_RANGE = 150;
  localparam int N_B2B = 300;
  localparam int TOTAL_OPS = N_EXACT + 2 * N_PROD + N_SPEC + N_RANGE + N_B2B;
  localparam real TIMEOUT_NS = 4.0 * TOTAL_OPS * 8.0 + 1000.0;

  logic   clk, rst_n, in_valid, out_valid;
  fp64_t  a, b, c, res;
  fpcsr_t fpcsr;
  flags_t raise;

  logic [31:0] seed = 32'd96052;
  fp64_t       exp_res_q[$];
  flags_t      exp_flags_q[$];
  string       name_q[$];

  fma_unit dut0 (
    .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .a(a), .b(b), .c(c), .fpcsr(fpcsr),
    .out_valid(out_valid), .res(res), .raise(raise)
  );

  bind fma_unit fma_unit_assertions u_assert0 (
    .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .out_valid(out_valid),
    .res(res), .raise(raise)
  );

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // the low bits of an LCG repeat quickly so only the upper bits are used
  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = next_rand();
    return int'(r[31:16]) % n;
  endfunction

  function automatic logic rand_bit();
    logic [31:0] r;
    r = next_rand();
    return r[31];
  endfunction

  function automatic logic [51:0] rand_frac(input int bits);  // only the top bits are set
    logic [63:0] r;
    r = {next_rand(), next_rand()};
    return (r[51:0] >> (52 - bits)) << (52 - bits);
  endfunction

  function automatic fp64_t make_fp(input logic s, input int e, input logic [51:0] f);
    return {s, 11'(e), f};
  endfunction

  function automatic fp64_t real_fma(input fp64_t x, input fp64_t y, input fp64_t z);
    return $realtobits($bitstoreal(x) * $bitstoreal(y) + $bitstoreal(z));
  endfunction

  function automatic fp64_t pick_special(input int k);
    case (k)
      0: return 64'h0000_0000_0000_0000;
      1: return 64'h8000_0000_0000_0000;
      2: return 64'h7ff0_0000_0000_0000;
      3: return 64'hfff0_0000_0000_0000;
      4: return 64'h7ff8_0000_0000_1234;  // quiet NaN with a payload
      5: return 64'h7ff0_0000_0000_0001;  // signalling NaN
      6: return 64'h3ff8_0000_0000_0000;
      7: return 64'hbff8_0000_0000_0000;
      8: return 64'h4008_0000_0000_0000;
      default: return 64'hc008_0000_0000_0000;
    endcase
  endfunction

  // the 106-bit integer product tells whether the real product was rounded
  task automatic product_model(input fp64_t x, input fp64_t y, output fp64_t r_even,
                               output fp64_t r_trunc, output logic inexact);
    logic [105:0] p;
    logic [51:0]  kept;
    p = {53'b0, 1'b1, x[51:0]} * {53'b0, 1'b1, y[51:0]};
    kept = p[105] ? p[104:53] : p[103:52];
    inexact = p[105] ? (p[52:0] != '0) : (p[51:0] != '0);
    r_even = real_fma(x, y, 64'h0);
    if (r_even[51:0] == kept) r_trunc = r_even;
    else r_trunc = {r_even[63], r_even[62:0] - 63'd1};  // one ulp toward zero
  endtask

  task automatic special_model(input fp64_t x, input fp64_t y, input fp64_t z,
                               output fp64_t er, output flags_t ef);
    logic nan, snan, mul_inv, prod_inf, add_inv, psign;
    nan = (x[62:52] == 11'h7ff && x[51:0] != 0) || (y[62:52] == 11'h7ff && y[51:0] != 0) ||
          (z[62:52] == 11'h7ff && z[51:0] != 0);
    snan = (x[62:51] == 12'hffe && x[50:0] != 0) || (y[62:51] == 12'hffe && y[50:0] != 0) ||
           (z[62:51] == 12'hffe && z[50:0] != 0);
    mul_inv = (x[62:0] == 63'h7ff0_0000_0000_0000 && y[62:0] == 0) ||
              (y[62:0] == 63'h7ff0_0000_0000_0000 && x[62:0] == 0);
    psign = x[63] ^ y[63];
    prod_inf = !nan && !mul_inv &&
               (x[62:0] == 63'h7ff0_0000_0000_0000 || y[62:0] == 63'h7ff0_0000_0000_0000);
    add_inv = prod_inf && z[62:0] == 63'h7ff0_0000_0000_0000 && psign != z[63];
    ef = '0;
    if (nan || mul_inv || add_inv) begin
      er = QNAN_DEFAULT;
      ef[FLG_INV] = snan || mul_inv || add_inv;
    end else if (prod_inf) er = {psign, 11'h7ff, 52'b0};
    else if (z[62:0] == 63'h7ff0_0000_0000_0000) er = z;
    else if ((x[62:0] == 0 || y[62:0] == 0) && z[62:0] == 0) er = {psign & z[63], 63'b0};
    else er = real_fma(x, y, z);  // the finite pool keeps this sum exact
  endtask

  // kind 0 exact sum, 1 rounded product, 2 special values, 3 range limits
  task automatic make_op(input int kind, output string name, output fp64_t x, output fp64_t y,
                         output fp64_t z, output fpcsr_t csr, output fp64_t er,
                         output flags_t ef);
    fp64_t t;
    logic  inx, daz;
    int    sel;
    ef = '0;
    csr = fpcsr_t'(rand_below(2));
    case (kind)
      0: begin
        name = "exact_sum";
        x = make_fp(rand_bit(), 1021 + rand_below(5), rand_frac(19));
        y = make_fp(rand_bit(), 1021 + rand_below(5), rand_frac(19));
        z = make_fp(rand_bit(), 1021 + rand_below(5), rand_frac(29));
        er = real_fma(x, y, z);
      end
      1: begin
        name = "rounded_product";
        x = make_fp(rand_bit(), 823 + rand_below(401), rand_frac(52));
        y = make_fp(rand_bit(), 823 + rand_below(401), rand_frac(52));
        z = '0;
        csr = '0;
        product_model(x, y, er, t, inx);
        ef[FLG_INX] = inx;
      end
      2: begin
        name = "special_value";
        x = pick_special(rand_below(10));
        y = pick_special(rand_below(10));
        z = pick_special(rand_below(10));
        special_model(x, y, z, er, ef);
      end
      default: begin
        sel = rand_below(3);
        z = '0;
        if (sel == 0) begin
          name = "overflow";
          x = make_fp(rand_bit(), 1700 + rand_below(300), rand_frac(52));
          y = make_fp(rand_bit(), 1700 + rand_below(300), rand_frac(52));
          er = csr[0] ? {x[63] ^ y[63], 11'h7fe, {52{1'b1}}} : {x[63] ^ y[63], 11'h7ff, 52'b0};
          ef[FLG_OVF] = 1'b1;
          ef[FLG_INX] = 1'b1;
        end else if (sel == 1) begin
          name = "underflow";
          x = make_fp(rand_bit(), 100 + rand_below(300), rand_frac(52));
          y = make_fp(rand_bit(), 100 + rand_below(300), rand_frac(52));
          er = {x[63] ^ y[63], 63'b0};
          ef[FLG_UNF] = 1'b1;
          ef[FLG_INX] = 1'b1;
        end else begin
          name = "subnormal_daz";
          daz = rand_bit();
          csr[CSR_DAZ] = daz;
          x = {rand_bit(), 11'h0, rand_frac(52) | 52'h1};
          y = make_fp(rand_bit(), 923 + rand_below(201), rand_frac(52));
          if (rand_bit()) begin  // the subnormal can sit in either factor
            t = x;
            x = y;
            y = t;
          end
          z = make_fp(rand_bit(), 923 + rand_below(201), rand_frac(52));
          er = z;
          ef[FLG_DEN] = daz;
        end
      end
    endcase
  endtask

  task automatic issue(input string name, input fp64_t x, input fp64_t y, input fp64_t z,
                       input fpcsr_t csr, input fp64_t er, input flags_t ef, input int gap);
    repeat (gap) begin
      @(posedge clk);
      in_valid <= 1'b0;
    end
    @(posedge clk);
    in_valid <= 1'b1;
    a <= x;
    b <= y;
    c <= z;
    fpcsr <= csr;
    exp_res_q.push_back(er);
    exp_flags_q.push_back(ef);
    name_q.push_back(name);
  endtask

  task automatic compare_res(input string name, input fp64_t exp_v, input fp64_t act_v);
    if (exp_v !== act_v) begin
      $display("[ERROR] %s res expected %h actual %h", name, exp_v, act_v);
      $display("RESULT: FAIL");
      $fatal(1, "result mismatch");
    end
  endtask

  task automatic compare_flags(input string name, input flags_t exp_v, input flags_t act_v);
    if (exp_v !== act_v) begin
      $display("[ERROR] %s raise expected %b actual %b", name, exp_v, act_v);
      $display("RESULT: FAIL");
      $fatal(1, "flag mismatch");
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: not all results came out of the DUT in time");
    $display("RESULT: FAIL");
    $fatal(1, "watchdog expired");
  end

  // outputs change on the rising edge, so they are read in the middle of the cycle
  always @(negedge clk) begin
    if (rst_n && out_valid) begin
      if (exp_res_q.size() == 0) begin
        $display("a result came out with no operation waiting for it");
        $display("RESULT: FAIL");
        $fatal(1, "unexpected result");
      end
      compare_res(name_q[0], exp_res_q.pop_front(), res);
      compare_flags(name_q.pop_front(), exp_flags_q.pop_front(), raise);
    end
  end

  initial begin
    string  name;
    fp64_t  x, y, z, er, r_trunc;
    fpcsr_t csr;
    flags_t ef;
    logic   inx;
    logic   burst;
    rst_n = 1'b0;
    in_valid = 1'b0;
    a = '0;
    b = '0;
    c = '0;
    fpcsr = '0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    for (int i = 0; i < N_EXACT; i++) begin
      make_op(0, name, x, y, z, csr, er, ef);
      issue(name, x, y, z, csr, er, ef, rand_below(4));
    end
    for (int i = 0; i < N_PROD; i++) begin
      make_op(1, name, x, y, z, csr, er, ef);
      issue(name, x, y, z, csr, er, ef, rand_below(4));
      product_model(x, y, er, r_trunc, inx);
      issue("truncation", x, y, z, 4'd1, r_trunc, inx ? flags_t'(1 << FLG_INX) : '0,
            rand_below(4));
    end
    for (int i = 0; i < N_SPEC; i++) begin
      make_op(2, name, x, y, z, csr, er, ef);
      issue(name, x, y, z, csr, er, ef, rand_below(4));
    end
    for (int i = 0; i < N_RANGE; i++) begin
      make_op(3, name, x, y, z, csr, er, ef);
      issue(name, x, y, z, csr, er, ef, rand_below(4));
    end
    burst = 1'b0;
    for (int i = 0; i < N_B2B; i++) begin
      if (rand_below(8) == 0) burst = ~burst;  // bursts issue on every clock
      make_op(rand_below(4), name, x, y, z, csr, er, ef);
      issue(name, x, y, z, csr, er, ef, burst ? 0 : rand_below(4));
    end

    @(posedge clk);
    in_valid <= 1'b0;
    while (exp_res_q.size() != 0) @(posedge clk);
    repeat (4) @(posedge clk);
    $display("RESULT: PASS");
    $finish;
  end

endmodule

/* fma_unit.f */
design/fp_pkg.sv
design/fpu_csr_pkg.sv
design/fma_unpack.sv
design/fma_multiply_align.sv
design/fma_normalize_round.sv
design/fma_unit.sv
dv/fma_unit_assertions.sv
dv/fma_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the FMA testbench with Verilator and runs it

verilator --binary --assert -Wno-fatal --top-module fma_unit_tb -Mdir obj_dir \
  -f fma_unit.f > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/Vfma_unit_tb > sim.log 2>&1

grep -qx "RESULT: PASS" sim.log && echo "simulation passed" || { cat sim.log; exit 1; }
